// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // Datapath
  localparam int WORD_W     = 32;
  localparam int BYTE_OFF_W = 2;   // Word aligned fetch

  typedef logic [WORD_W-1:0] word_t;

  localparam word_t RESET_PC = '0;
  localparam word_t PC_STEP  = word_t'(4);

  // Branch target buffer sizing
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = WORD_W - BTB_IDX_W - BYTE_OFF_W;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;
  typedef logic [1:0]           counter_t;   // 2 and 3 predict taken

  localparam counter_t CNT_MIN        = 2'd0;
  localparam counter_t CNT_WEAK_TAKEN = 2'd2;
  localparam counter_t CNT_MAX        = 2'd3;

  // Instruction cache sizing, one word per line
  localparam int ICACHE_LINES = 16;
  localparam int ICACHE_IDX_W = 4;
  localparam int ICACHE_TAG_W = WORD_W - ICACHE_IDX_W - BYTE_OFF_W;

  typedef logic [ICACHE_IDX_W-1:0] icache_idx_t;
  typedef logic [ICACHE_TAG_W-1:0] icache_tag_t;

  typedef enum logic {
    IC_IDLE,     // Lookup, hit answers same cycle
    IC_REFILL    // Waiting on external memory
  } icache_state_t;

endpackage

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  logic  freeze,
  input  logic  jump,
  input  logic  misprediction,
  input  word_t correct_pc,
  input  word_t imemload,
  input  word_t pc_prediction,
  input  logic  predicted_taken,
  output logic  imemren,
  output word_t imemaddr,
  output word_t pc,
  output word_t instr
);

  word_t pc_q;
  word_t next_pc;
  logic  redirect;
  logic  advance;

  // Jump and misprediction are one-cycle strobes, taken even mid refill
  assign redirect = jump || misprediction;
  assign advance  = ihit && !freeze;

  always_comb begin
    next_pc = pc_q;
    if (redirect) begin
      next_pc = correct_pc;
    end else if (advance) begin
      if (predicted_taken) begin
        next_pc = pc_prediction;   // BTB hit, counter taken
      end else begin
        next_pc = pc_q + PC_STEP;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

  // Fetch request comes up the cycle after reset and stays up
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      imemren <= 1'b0;
    end else begin
      imemren <= 1'b1;
    end
  end

  assign imemaddr = pc_q;

  // Bubble unless the cache answered this cycle
  assign pc    = ihit ? pc_q : '0;
  assign instr = ihit ? imemload : '0;

  pc_word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    pc_q[BYTE_OFF_W-1:0] == '0)
    else $error("fetch PC %h is not word aligned", pc_q);

endmodule

`default_nettype wire

// ==== src/branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_predictor import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t pc,
  input  logic  update_btb,
  input  logic  branch_outcome,
  input  word_t update_pc,
  input  word_t branch_target,
  output logic  predicted_outcome,
  output word_t predicted_target
);

  logic [BTB_ENTRIES-1:0] valid;
  btb_tag_t               tags     [BTB_ENTRIES];
  word_t                  targets  [BTB_ENTRIES];
  counter_t               counters [BTB_ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  logic     rd_hit;

  btb_idx_t wr_idx;
  btb_tag_t wr_tag;
  logic     wr_hit;
  logic     wr_en;
  counter_t new_count;

  // Lookup side
  assign rd_idx = pc[BYTE_OFF_W +: BTB_IDX_W];
  assign rd_tag = pc[WORD_W-1 -: BTB_TAG_W];
  assign rd_hit = valid[rd_idx] && (tags[rd_idx] == rd_tag);

  assign predicted_outcome = rd_hit && (counters[rd_idx] >= CNT_WEAK_TAKEN);
  assign predicted_target  = predicted_outcome ? targets[rd_idx] : '0;

  // Update side
  assign wr_idx = update_pc[BYTE_OFF_W +: BTB_IDX_W];
  assign wr_tag = update_pc[WORD_W-1 -: BTB_TAG_W];
  assign wr_hit = valid[wr_idx] && (tags[wr_idx] == wr_tag);

  // A not-taken branch with no entry leaves the table alone
  assign wr_en = update_btb && (wr_hit || branch_outcome);

  always_comb begin
    new_count = counters[wr_idx];
    if (!wr_hit) begin
      new_count = CNT_WEAK_TAKEN;   // Fresh allocation
    end else if (branch_outcome) begin
      if (counters[wr_idx] != CNT_MAX) begin
        new_count = counters[wr_idx] + 2'd1;
      end
    end else begin
      if (counters[wr_idx] != CNT_MIN) begin
        new_count = counters[wr_idx] - 2'd1;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      tags[wr_idx]     <= wr_tag;
      counters[wr_idx] <= new_count;
      if (branch_outcome) begin
        targets[wr_idx] <= branch_target;   // Keep last taken target
      end
    end
  end

  update_pc_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    update_btb |-> update_pc[BYTE_OFF_W-1:0] == '0)
    else $error("BTB update at unaligned PC %h", update_pc);

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  logic  freeze,
  input  logic  jump,
  input  logic  misprediction,
  input  logic  update_btb,
  input  logic  branch_outcome,
  input  word_t correct_pc,
  input  word_t update_pc,
  input  word_t branch_target,
  input  word_t imemload,
  output logic  imemren,
  output word_t imemaddr,
  output word_t pc,
  output word_t instr,
  output logic  predicted_outcome
);

  word_t fu_pc;
  word_t fu_instr;
  logic  btb_taken;
  word_t btb_target;

  word_t prev_pc;
  word_t prev_instr;
  logic  prev_pred;

  word_t save_pc;   // Redirect target we are waiting for
  logic  missed;
  logic  mispredict_now;
  logic  resume;
  logic  squash;

  assign mispredict_now = update_btb && misprediction;
  assign resume         = missed && ihit && (imemaddr == save_pc);
  assign squash         = jump || mispredict_now || (missed && !resume);

  always_comb begin
    if (freeze) begin
      pc                = prev_pc;
      instr             = prev_instr;
      predicted_outcome = prev_pred;
    end else if (squash) begin
      pc                = '0;
      instr             = '0;
      predicted_outcome = 1'b0;
    end else begin
      pc                = fu_pc;
      instr             = fu_instr;
      predicted_outcome = btb_taken && ihit;
    end
  end

  // Hold copy of what was shown on the last unfrozen cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      prev_pc    <= '0;
      prev_instr <= '0;
      prev_pred  <= 1'b0;
    end else if (!freeze) begin
      prev_pc    <= pc;
      prev_instr <= instr;
      prev_pred  <= predicted_outcome;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      missed  <= 1'b0;
      save_pc <= '0;
    end else if (mispredict_now) begin
      missed  <= 1'b1;
      save_pc <= correct_pc;
    end else if (jump || resume) begin
      missed  <= 1'b0;   // Jump target supersedes a pending recovery
    end
  end

  fetch_unit i_fetch_unit (
    .CLK             (CLK),
    .nRST            (nRST),
    .ihit            (ihit),
    .freeze          (freeze),
    .jump            (jump),
    .misprediction   (mispredict_now),
    .correct_pc      (correct_pc),
    .imemload        (imemload),
    .pc_prediction   (btb_target),
    .predicted_taken (btb_taken),
    .imemren         (imemren),
    .imemaddr        (imemaddr),
    .pc              (fu_pc),
    .instr           (fu_instr)
  );

  branch_predictor i_branch_predictor (
    .CLK               (CLK),
    .nRST              (nRST),
    .pc                (imemaddr),   // Predict on the address being fetched
    .update_btb        (update_btb),
    .branch_outcome    (branch_outcome),
    .update_pc         (update_pc),
    .branch_target     (branch_target),
    .predicted_outcome (btb_taken),
    .predicted_target  (btb_target)
  );

endmodule

`default_nettype wire

// ==== src/instr_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_cache import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  imemren,
  input  word_t imemaddr,
  output logic  ihit,
  output word_t imemload,
  output logic  mem_ren,
  output word_t mem_addr,
  input  word_t mem_load,
  input  logic  mem_ready
);

  icache_state_t state;
  icache_state_t next_state;

  logic [ICACHE_LINES-1:0] valid;
  icache_tag_t             tags [ICACHE_LINES];
  word_t                   data [ICACHE_LINES];

  word_t       refill_addr;   // Missing word, held for the whole refill
  icache_idx_t idx;
  icache_tag_t tag;
  logic        tag_match;
  logic        miss;
  icache_idx_t fill_idx;
  icache_tag_t fill_tag;
  logic        fill_done;

  assign idx       = imemaddr[BYTE_OFF_W +: ICACHE_IDX_W];
  assign tag       = imemaddr[WORD_W-1 -: ICACHE_TAG_W];
  assign tag_match = valid[idx] && (tags[idx] == tag);

  assign ihit     = imemren && (state == IC_IDLE) && tag_match;
  assign imemload = data[idx];
  assign miss     = imemren && (state == IC_IDLE) && !tag_match;

  assign fill_idx  = refill_addr[BYTE_OFF_W +: ICACHE_IDX_W];
  assign fill_tag  = refill_addr[WORD_W-1 -: ICACHE_TAG_W];
  assign fill_done = (state == IC_REFILL) && mem_ready;

  assign mem_ren  = (state == IC_REFILL);
  assign mem_addr = refill_addr;

  always_comb begin
    next_state = state;
    case (state)
      IC_IDLE: begin
        if (miss) begin
          next_state = IC_REFILL;
        end
      end
      IC_REFILL: begin
        if (mem_ready) begin
          next_state = IC_IDLE;   // Line is written, lookup hits next cycle
        end
      end
      default: next_state = IC_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IC_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (fill_done) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (miss) begin
      refill_addr <= imemaddr;
    end
    if (fill_done) begin
      tags[fill_idx] <= fill_tag;
      data[fill_idx] <= mem_load;
    end
  end

  mem_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
    mem_ren && !mem_ready |=> mem_ren && $stable(mem_addr))
    else $error("refill address moved while waiting on memory");

endmodule

`default_nettype wire

// ==== src/fetch_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_subsystem import isa_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  freeze,
  input  logic  jump,
  input  logic  misprediction,
  input  logic  update_btb,
  input  logic  branch_outcome,
  input  logic  mem_ready,
  input  word_t correct_pc,
  input  word_t update_pc,
  input  word_t branch_target,
  input  word_t mem_load,
  output word_t pc,
  output word_t instr,
  output logic  predicted_outcome,
  output logic  mem_ren,
  output word_t mem_addr
);

  // Fetch stage to cache
  logic  ihit;
  logic  imemren;
  word_t imemaddr;
  word_t imemload;

  fetch_stage i_fetch_stage (
    .CLK               (CLK),
    .nRST              (nRST),
    .ihit              (ihit),
    .freeze            (freeze),
    .jump              (jump),
    .misprediction     (misprediction),
    .update_btb        (update_btb),
    .branch_outcome    (branch_outcome),
    .correct_pc        (correct_pc),
    .update_pc         (update_pc),
    .branch_target     (branch_target),
    .imemload          (imemload),
    .imemren           (imemren),
    .imemaddr          (imemaddr),
    .pc                (pc),
    .instr             (instr),
    .predicted_outcome (predicted_outcome)
  );

  instr_cache i_instr_cache (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemren   (imemren),
    .imemaddr  (imemaddr),
    .ihit      (ihit),
    .imemload  (imemload),
    .mem_ren   (mem_ren),
    .mem_addr  (mem_addr),
    .mem_load  (mem_load),
    .mem_ready (mem_ready)
  );

endmodule

`default_nettype wire

// ==== tests/tb_fetch_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_subsystem import isa_pkg::*;;

  localparam int FETCH_TIMEOUT = 40;   // Cycles allowed per returned fetch
  localparam int CASE_WORDS    = 512;

  logic  CLK;
  logic  nRST;
  logic  freeze;
  logic  jump;
  logic  misprediction;
  logic  update_btb;
  logic  branch_outcome;
  logic  mem_ready;
  word_t correct_pc;
  word_t update_pc;
  word_t branch_target;
  word_t mem_load;
  word_t pc;
  word_t instr;
  logic  predicted_outcome;
  logic  mem_ren;
  word_t mem_addr;

  word_t mem   [256];
  word_t cases [CASE_WORDS];

  // Reference branch target buffer
  logic     rb_valid  [BTB_ENTRIES];
  btb_tag_t rb_tag    [BTB_ENTRIES];
  word_t    rb_target [BTB_ENTRIES];
  counter_t rb_count  [BTB_ENTRIES];

  // Reference cache, one resident address per line
  logic  rc_valid [ICACHE_LINES];
  word_t rc_addr  [ICACHE_LINES];

  word_t  exp_pc;      // Next PC the fetch stage must show
  word_t  held_pc;
  word_t  held_instr;
  logic   held_pred;
  word_t  last_pc;
  logic   last_pred;
  word_t  req_addr;
  int     fetched;
  int     errors;
  int     lat_cnt;
  integer seed;
  logic   aborted;

  fetch_subsystem i_fetch_subsystem (
    .CLK               (CLK),
    .nRST              (nRST),
    .freeze            (freeze),
    .jump              (jump),
    .misprediction     (misprediction),
    .update_btb        (update_btb),
    .branch_outcome    (branch_outcome),
    .mem_ready         (mem_ready),
    .correct_pc        (correct_pc),
    .update_pc         (update_pc),
    .branch_target     (branch_target),
    .mem_load          (mem_load),
    .pc                (pc),
    .instr             (instr),
    .predicted_outcome (predicted_outcome),
    .mem_ren           (mem_ren),
    .mem_addr          (mem_addr)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic word_t mem_word(input word_t a);
    return mem[a[9:2]];
  endfunction

  function automatic logic btb_predicts(input word_t a);
    btb_idx_t i;
    i = a[5:2];
    return rb_valid[i] && (rb_tag[i] == a[31:6]) && (rb_count[i] >= 2'd2);
  endfunction

  task automatic btb_train(input logic taken, input word_t a, input word_t tgt);
    btb_idx_t i;
    logic     hit;
    i   = a[5:2];
    hit = rb_valid[i] && (rb_tag[i] == a[31:6]);
    if (!hit && taken) begin
      rb_valid[i] = 1'b1;
      rb_tag[i]   = a[31:6];
      rb_count[i] = 2'd2;   // New entry starts weakly taken
    end else if (hit && taken && rb_count[i] != 2'd3) begin
      rb_count[i] = rb_count[i] + 2'd1;
    end else if (hit && !taken && rb_count[i] != 2'd0) begin
      rb_count[i] = rb_count[i] - 2'd1;
    end
    if (taken) begin
      rb_target[i] = tgt;
    end
  endtask

  task automatic note_refill(input word_t a);
    icache_idx_t i;
    i = a[5:2];
    if (rc_valid[i] && rc_addr[i] == a) begin
      errors++;
      $display("Refill at %0t for address %h that is already cached", $time, a);
    end
    rc_valid[i] = 1'b1;
    rc_addr[i]  = a;
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t want);
    errors++;
    $display("FAILED %s at %0t: got %h expected %h", name, $time, got, want);
  endtask

  // External word memory, 1 to 4 cycles per refill
  always @(negedge CLK) begin
    if (mem_ready) begin
      mem_ready = 1'b0;
    end else if (mem_ren) begin
      if (lat_cnt == 0) begin
        lat_cnt  = ($random(seed) & 3) + 1;
        req_addr = mem_addr;   // Must hold until mem_ready
      end else if (mem_addr !== req_addr) begin
        report_mismatch("mem_addr", mem_addr, req_addr);
      end
      lat_cnt = lat_cnt - 1;
      if (lat_cnt == 0) begin
        note_refill(mem_addr);
        mem_load  = mem_word(mem_addr);
        mem_ready = 1'b1;
      end
    end
  end

  task automatic sample_outputs(input logic frozen, input logic squashed);
    logic bubble;
    bubble = (pc === '0) && (instr === '0);
    if (frozen) begin
      if (pc !== held_pc) report_mismatch("pc", pc, held_pc);
      if (instr !== held_instr) report_mismatch("instr", instr, held_instr);
      if (predicted_outcome !== held_pred)
        report_mismatch("predicted_outcome", predicted_outcome, held_pred);
      return;
    end
    if (squashed || bubble) begin
      if (pc !== '0) report_mismatch("pc", pc, '0);
      if (instr !== '0) report_mismatch("instr", instr, '0);
      if (predicted_outcome !== 1'b0)
        report_mismatch("predicted_outcome", predicted_outcome, 1'b0);
      held_pc    = '0;
      held_instr = '0;
      held_pred  = 1'b0;
    end else begin
      if (pc !== exp_pc) report_mismatch("pc", pc, exp_pc);
      if (instr !== mem_word(exp_pc)) report_mismatch("instr", instr, mem_word(exp_pc));
      if (predicted_outcome !== btb_predicts(exp_pc))
        report_mismatch("predicted_outcome", predicted_outcome, btb_predicts(exp_pc));
      held_pc    = exp_pc;
      held_instr = mem_word(exp_pc);
      held_pred  = btb_predicts(exp_pc);
      last_pc    = pc;
      last_pred  = predicted_outcome;
      fetched++;
      exp_pc = btb_predicts(exp_pc) ? rb_target[exp_pc[5:2]] : exp_pc + 32'd4;
    end
  endtask

  task automatic drive_cycle(input logic frz, input logic jmp, input logic upd,
                             input logic taken, input logic mis, input word_t cpc,
                             input word_t upc, input word_t tgt);
    @(negedge CLK);
    freeze         = frz;
    jump           = jmp;
    update_btb     = upd;
    branch_outcome = taken;
    misprediction  = mis;
    correct_pc     = cpc;
    update_pc      = upc;
    branch_target  = tgt;
    #2;
    sample_outputs(frz, jmp || (upd && mis));
    if (upd) btb_train(taken, upc, tgt);
    if (jmp || (upd && mis)) exp_pc = cpc;
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic hold_freeze(input int n);
    repeat (n) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  // Wait for n returned fetches, each with its own timeout
  task automatic run_fetches(input int n, input word_t want_pc, input logic want_pred);
    int k;
    int start;
    int waited;
    for (k = 0; k < n && !aborted; k++) begin
      start  = fetched;
      waited = 0;
      while (fetched == start && waited < FETCH_TIMEOUT) begin
        idle_cycle();
        waited++;
      end
      if (fetched == start) begin
        aborted = 1'b1;
        errors++;
        $display("Timeout: no fetch came back within %0d cycles, waiting for pc %h",
                 FETCH_TIMEOUT, exp_pc);
      end
    end
    if (!aborted) begin
      if (last_pc !== want_pc) report_mismatch("pc", last_pc, want_pc);
      if (last_pred !== want_pred) report_mismatch("predicted_outcome", last_pred, want_pred);
    end
  endtask

  initial begin
    int i;
    int p;
    seed           = 31;
    nRST           = 1'b0;
    freeze         = 1'b0;
    jump           = 1'b0;
    misprediction  = 1'b0;
    update_btb     = 1'b0;
    branch_outcome = 1'b0;
    mem_ready      = 1'b0;
    correct_pc     = '0;
    update_pc      = '0;
    branch_target  = '0;
    mem_load       = '0;
    req_addr       = '0;
    errors         = 0;
    fetched        = 0;
    lat_cnt        = 0;
    aborted        = 1'b0;
    p              = CASE_WORDS;
    for (i = 0; i < 256; i++) mem[i] = 32'hc0de_0000 ^ word_t'(i * 4);
    for (i = 0; i < BTB_ENTRIES; i++) rb_valid[i] = 1'b0;
    for (i = 0; i < ICACHE_LINES; i++) rc_valid[i] = 1'b0;

    $readmemh("tests/fetch_cases.txt", cases);
    if ($isunknown(cases[0])) begin
      errors++;
      $display("Case file tests/fetch_cases.txt could not be read");
    end else begin
      for (i = 0; i < cases[0]; i++) mem[i] = cases[1 + i];   // Program from address 0
      p = 1 + cases[0];
    end

    repeat (16) @(negedge CLK);
    if (pc !== '0) report_mismatch("pc", pc, '0);
    if (instr !== '0) report_mismatch("instr", instr, '0);
    if (predicted_outcome !== 1'b0)
      report_mismatch("predicted_outcome", predicted_outcome, 1'b0);
    if (mem_ren !== 1'b0) report_mismatch("mem_ren", mem_ren, 1'b0);
    nRST       = 1'b1;
    exp_pc     = RESET_PC;
    held_pc    = '0;
    held_instr = '0;
    held_pred  = 1'b0;

    while (!aborted && p < CASE_WORDS - 6 && cases[p] !== '0 && !$isunknown(cases[p])) begin
      case (cases[p])
        1: begin
          run_fetches(cases[p+1], cases[p+2], cases[p+3][0]);
          p += 4;
        end
        2: begin
          hold_freeze(cases[p+1]);
          p += 2;
        end
        3: begin
          drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, cases[p+1], '0, '0);
          p += 2;
        end
        4: begin
          drive_cycle(1'b0, 1'b0, 1'b1, cases[p+1][0], cases[p+4][0],
                      cases[p+5], cases[p+2], cases[p+3]);
          p += 6;
        end
        default: begin
          errors++;
          $display("Unknown event code %h at case word %0d", cases[p], p);
          aborted = 1'b1;
        end
      endcase
    end

    $display("Checked %0d fetches, %0d errors", fetched, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/fetch_cases.txt ====
// Program: word count, then that many words placed from address 0 (all hex)
// Events: 1 n pc pred | 2 n | 3 target | 4 taken pc target mispredict correct_pc | 0 end
18
00000013 00100093 00200113 00308193
00410213 00518293 00620313 00728393
00830413 00938493 00a40513 00b48593
00c50613 00d58693 00e60713 00f68793
01070813 01178893 01280913 01388993
01490a13 015a0a93 016a8b13 017b0b93
// Straight-line fetch from reset, freeze holding pc 1c
1 8 1c 0
2 5
1 2 24 0
// Jump back into cached lines
3 8
1 4 14 0
// Branch at 18 trained taken twice, target 40
4 1 18 40 0 0
4 1 18 40 0 0
3 10
1 3 18 1
1 1 40 0
// Branch at 18 resolves not taken, recover at 1c
4 0 18 40 1 1c
1 2 20 0
4 0 18 40 0 0
3 14
1 3 1c 0
// Taken branch at 30 learned through a misprediction
4 1 30 8 1 8
1 6 1c 0
1 5 30 1
1 1 8 0
2 3
1 2 10 0
0

// ==== tb.f ====
src/isa_pkg.sv
src/fetch_unit.sv
src/branch_predictor.sv
src/fetch_stage.sv
src/instr_cache.sv
src/fetch_subsystem.sv
tests/tb_fetch_subsystem.sv

// ==== Bender.yml ====
package:
  name: fetch_subsystem

sources:
  - files:
      - src/isa_pkg.sv
      - src/fetch_unit.sv
      - src/branch_predictor.sv
      - src/fetch_stage.sv
      - src/instr_cache.sv
      - src/fetch_subsystem.sv
  - target: test
    files:
      - tests/tb_fetch_subsystem.sv
